//--- src/axil_target_pkg.sv
package axil_target_pkg;

	////////////////////////////////////////
	// bus widths
	////////////////////////////////////////

	localparam int ADDR_WIDTH = 15;
	localparam int DATA_WIDTH = 32;
	localparam int OFFSET_WIDTH = 12;	// register window inside a target
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;	// one bit per byte
	typedef logic [OFFSET_WIDTH-1:0] offset_t;

	////////////////////////////////////////
	// memory target states
	////////////////////////////////////////

	typedef enum logic [2:0] {
		idle = 3'b000,
		read_data = 3'b001,	// arready pulse, fetch word
		read_complete = 3'b010,	// rvalid held until rready
		write_data = 3'b011,	// address taken, waiting for wvalid
		write_complete = 3'b100	// memory update
	} target_state_t;

endpackage

//--- src/axil_mem_target.sv
module axil_mem_target #(
	parameter int mem_addr_bits = 8
) (
	input logic axi_clk,
	input logic axi_reset_n,
	input logic enable,
	input logic awvalid,
	input axil_target_pkg::addr_t awaddr,
	input logic wvalid,
	input axil_target_pkg::data_t wdata,
	input logic arvalid,
	input axil_target_pkg::addr_t araddr,
	input logic rready,
	output logic awready,
	output logic wready,
	output logic arready,
	output logic rvalid,
	output axil_target_pkg::data_t rdata
);

	import axil_target_pkg::*;

	localparam int mem_depth = 1 << mem_addr_bits;

	target_state_t state;
	addr_t addr_reg;
	data_t wdata_reg;
	data_t mem [0:mem_depth-1];
	logic [mem_addr_bits-1:0] mem_index;

	logic ar_take;
	logic aw_take;
	logic w_take;

	// read has priority when both arrive in idle
	assign ar_take = enable && (state == idle) && arvalid;
	assign aw_take = enable && (state == idle) && !arvalid && awvalid;
	assign w_take = enable && wvalid && (aw_take || (state == write_data));

	assign mem_index = addr_reg[mem_addr_bits-1:0];

	////////////////////////////////////////
	// captured address and write data
	////////////////////////////////////////

	always_ff @(posedge axi_clk) begin
		if (ar_take) begin
			addr_reg <= araddr;
		end else if (aw_take) begin
			addr_reg <= awaddr;
		end
		if (w_take) begin
			wdata_reg <= wdata;
		end
	end

	always_ff @(posedge axi_clk) begin
		if (enable && (state == write_complete)) begin
			mem[mem_index] <= wdata_reg;	// one edge after wready
		end
	end

	////////////////////////////////////////
	// handshake FSM
	////////////////////////////////////////

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			state <= idle;
		end else if (!enable) begin
			// deselected, park in idle with quiet outputs
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			state <= idle;
		end else begin
			case (state)
			idle: begin
				if (ar_take) begin
					arready <= 1'b1;
					state <= read_data;
				end else if (aw_take) begin
					awready <= 1'b1;
					wready <= wvalid;	// data may come together with address
					state <= wvalid ? write_complete : write_data;
				end
			end
			read_data: begin
				arready <= 1'b0;
				rdata <= mem[mem_index];
				rvalid <= 1'b1;
				state <= read_complete;
			end
			read_complete: begin
				if (rready) begin
					rdata <= '0;
					rvalid <= 1'b0;
					state <= idle;
				end
			end
			write_data: begin
				awready <= 1'b0;
				if (w_take) begin
					wready <= 1'b1;
					state <= write_complete;
				end
			end
			write_complete: begin
				awready <= 1'b0;
				wready <= 1'b0;
				state <= idle;
			end
			default: begin
				state <= idle;
			end
			endcase
		end
	end

endmodule

//--- src/axil_reg_target.sv
module axil_reg_target #(
	parameter int reg_width = 32
) (
	input logic axi_clk,
	input logic axi_reset_n,
	input logic enable,
	input logic awvalid,
	input axil_target_pkg::addr_t awaddr,
	input logic wvalid,
	input axil_target_pkg::data_t wdata,
	input axil_target_pkg::strb_t wstrb,
	output logic awready,
	output logic wready,
	output logic arready,
	output logic rvalid,
	output axil_target_pkg::data_t rdata,
	output logic [reg_width-1:0] cfg
);

	import axil_target_pkg::*;

	offset_t offset;
	logic wr_hit;

	assign offset = awaddr[OFFSET_WIDTH-1:0];
	assign wr_hit = enable && awvalid && wvalid;

	// zero wait handshake, both readies together
	assign awready = wr_hit;
	assign wready = wr_hit;

	// read side always answers while selected
	assign arready = enable;
	assign rvalid = enable;
	assign rdata = enable ? data_t'(cfg) : '0;

	////////////////////////////////////////
	// config register
	////////////////////////////////////////

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			cfg <= '0;
		end else if (wr_hit && (offset == '0)) begin
			for (int i = 0; i < reg_width; i++) begin
				if (wstrb[i / 8]) begin	// byte lane of bit i
					cfg[i] <= wdata[i];
				end
			end
		end
	end

endmodule

//--- src/axil_target_cluster.sv
module axil_target_cluster #(
	parameter int mem_addr_bits = 8,
	parameter int switch_reg_width = 32,
	parameter int serdes_reg_width = 2
) (
	input logic axi_clk,
	input logic axi_reset_n,

	// shared bus from the master
	input logic awvalid,
	input axil_target_pkg::addr_t awaddr,
	input logic wvalid,
	input axil_target_pkg::data_t wdata,
	input axil_target_pkg::strb_t wstrb,
	input logic arvalid,
	input axil_target_pkg::addr_t araddr,
	input logic rready,
	output logic awready,
	output logic wready,
	output logic arready,
	output logic rvalid,
	output axil_target_pkg::data_t rdata,

	// target selects from the controller
	input logic la_enable,
	input logic up_enable,
	input logic as_enable,
	input logic is_enable,

	output axil_target_pkg::data_t switch_cfg,
	output logic rx_enable,
	output logic tx_enable
);

	import axil_target_pkg::*;

	logic la_awready, la_wready, la_arready, la_rvalid;
	logic up_awready, up_wready, up_arready, up_rvalid;
	logic as_awready, as_wready, as_arready, as_rvalid;
	logic is_awready, is_wready, is_arready, is_rvalid;
	data_t la_rdata;
	data_t up_rdata;
	data_t as_rdata;
	data_t is_rdata;
	logic [serdes_reg_width-1:0] serdes_cfg;

	////////////////////////////////////////
	// memory targets
	////////////////////////////////////////

	axil_mem_target #(
		.mem_addr_bits(mem_addr_bits)
	) la_target (
		.axi_clk(axi_clk),
		.axi_reset_n(axi_reset_n),
		.enable(la_enable),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wdata(wdata),
		.arvalid(arvalid),
		.araddr(araddr),
		.rready(rready),
		.awready(la_awready),
		.wready(la_wready),
		.arready(la_arready),
		.rvalid(la_rvalid),
		.rdata(la_rdata)
	);

	axil_mem_target #(
		.mem_addr_bits(mem_addr_bits)
	) up_target (
		.axi_clk(axi_clk),
		.axi_reset_n(axi_reset_n),
		.enable(up_enable),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wdata(wdata),
		.arvalid(arvalid),
		.araddr(araddr),
		.rready(rready),
		.awready(up_awready),
		.wready(up_wready),
		.arready(up_arready),
		.rvalid(up_rvalid),
		.rdata(up_rdata)
	);

	////////////////////////////////////////
	// register targets
	////////////////////////////////////////

	axil_reg_target #(
		.reg_width(switch_reg_width)
	) switch_target (
		.axi_clk(axi_clk),
		.axi_reset_n(axi_reset_n),
		.enable(as_enable),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wdata(wdata),
		.wstrb(wstrb),
		.awready(as_awready),
		.wready(as_wready),
		.arready(as_arready),
		.rvalid(as_rvalid),
		.rdata(as_rdata),
		.cfg(switch_cfg)
	);

	axil_reg_target #(
		.reg_width(serdes_reg_width)
	) serdes_target (
		.axi_clk(axi_clk),
		.axi_reset_n(axi_reset_n),
		.enable(is_enable),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wdata(wdata),
		.wstrb(wstrb),
		.awready(is_awready),
		.wready(is_wready),
		.arready(is_arready),
		.rvalid(is_rvalid),
		.rdata(is_rdata),
		.cfg(serdes_cfg)
	);

	assign rx_enable = serdes_cfg[0];
	assign tx_enable = serdes_cfg[1];

	// deselected targets drive zero, so OR is enough
	assign awready = la_awready | up_awready | as_awready | is_awready;
	assign wready = la_wready | up_wready | as_wready | is_wready;
	assign arready = la_arready | up_arready | as_arready | is_arready;
	assign rvalid = la_rvalid | up_rvalid | as_rvalid | is_rvalid;
	assign rdata = la_rdata | up_rdata | as_rdata | is_rdata;

endmodule

//--- testbench/axil_target_cluster_assert.sv
module axil_target_cluster_assert (
	input logic axi_clk,
	input logic axi_reset_n,
	input logic enable,
	input logic awready,
	input logic wready,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input axil_target_pkg::data_t rdata
);

	arready_pulse: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		arready |=> !arready)
		else $error("arready high for more than one cycle");

	// response held until the master takes it
	rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		enable && rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed before rready");

	quiet_when_off: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		!enable |=> !(awready || wready || arready || rvalid) && rdata == '0)
		else $error("deselected memory target drove a response");

endmodule

bind axil_mem_target axil_target_cluster_assert handshake_check (
	.axi_clk(axi_clk),
	.axi_reset_n(axi_reset_n),
	.enable(enable),
	.awready(awready),
	.wready(wready),
	.arready(arready),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata)
);

//--- testbench/axil_tb_tasks.svh
////////////////////////////////////////
// typed compares
////////////////////////////////////////

task automatic compare_data(input string name, input data_t got_value, input data_t expected);
	if (got_value !== expected) begin
		value_errors++;
		$display("FAILED %s: got %h, expected %h", name, got_value, expected);
	end
endtask

task automatic compare_bit(input string name, input logic got_value, input logic expected);
	if (got_value !== expected) begin
		value_errors++;
		$display("FAILED %s: got %h, expected %h", name, got_value, expected);
	end
endtask

function automatic logic flag(input string name);
	if (name == "awready") return awready;
	if (name == "wready") return wready;
	if (name == "arready") return arready;
	return rvalid;
endfunction

// a flag seen at a falling edge is taken at the next rising edge
task automatic wait_for(input string name);
	int cycles;
	cycles = 0;
	while (!flag(name) && cycles < bus_timeout) begin
		@(negedge axi_clk);
		cycles++;
	end
	if (!flag(name)) begin
		protocol_errors++;
		$display("no %s from the DUT within %0d cycles", name, bus_timeout);
	end
endtask

////////////////////////////////////////
// bus master
////////////////////////////////////////

task automatic write_both(input addr_t addr, input data_t word, input strb_t strb);
	@(negedge axi_clk);
	awaddr = addr;
	wdata = word;
	wstrb = strb;
	awvalid = 1'b1;
	wvalid = 1'b1;
	@(negedge axi_clk);
	wait_for("awready");
	compare_bit("wready", wready, 1'b1);	// same cycle as awready
	@(negedge axi_clk);
	awvalid = 1'b0;
	wvalid = 1'b0;
endtask

task automatic write_split(input addr_t addr, input data_t word, input int gap);
	@(negedge axi_clk);
	awaddr = addr;
	wstrb = '1;
	awvalid = 1'b1;
	@(negedge axi_clk);
	wait_for("awready");
	compare_bit("wready", wready, 1'b0);	// no data offered yet
	@(negedge axi_clk);
	awvalid = 1'b0;
	repeat (gap) @(negedge axi_clk);
	wdata = word;
	wvalid = 1'b1;
	@(negedge axi_clk);
	wait_for("wready");
	compare_bit("awready", awready, 1'b0);
	@(negedge axi_clk);
	wvalid = 1'b0;
endtask

// hold is the number of cycles rready stays low once rvalid is up
task automatic read_word(input addr_t addr, input int hold, output data_t word);
	@(negedge axi_clk);
	araddr = addr;
	arvalid = 1'b1;
	rready = (hold == 0);
	@(negedge axi_clk);
	wait_for("arready");
	@(negedge axi_clk);
	arvalid = 1'b0;
	wait_for("rvalid");
	word = rdata;
	repeat (hold) begin
		@(negedge axi_clk);
		compare_bit("rvalid", rvalid, 1'b1);
		compare_data("rdata", rdata, word);
	end
	rready = 1'b1;
	@(negedge axi_clk);
	rready = 1'b0;
endtask

//--- testbench/axil_target_cluster_tb.sv
module axil_target_cluster_tb;

	import axil_target_pkg::*;

	localparam int mem_bits = 8;
	localparam int bus_timeout = 16;	// cycles per handshake wait
	localparam int num_words = 8;
	localparam int num_transactions = 1 + 5 * num_words + 8 + 4 + 6 + 6;
	localparam int watchdog_cycles = num_transactions * 4 * bus_timeout + 200;

	logic axi_clk;
	logic axi_reset_n;
	logic awvalid, wvalid, arvalid, rready;
	logic awready, wready, arready, rvalid;
	logic la_enable, up_enable, as_enable, is_enable;
	logic rx_enable, tx_enable;
	logic [1:0] serdes_expected;
	addr_t awaddr, araddr;
	addr_t addr_list [num_words];
	data_t wdata, rdata, switch_cfg, got;
	data_t la_model [1 << mem_bits];
	data_t up_model [1 << mem_bits];
	strb_t wstrb;
	int value_errors = 0;
	int protocol_errors = 0;

	axil_target_cluster #(
		.mem_addr_bits(mem_bits),
		.switch_reg_width(32),
		.serdes_reg_width(2)
	) UUT (.*);

	`include "axil_tb_tasks.svh"

	initial begin
		axi_clk = 1'b0;
		forever #5 axi_clk = ~axi_clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge axi_clk);
		$display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
		$display("*** FAILED ***");
		$finish;
	end

	task automatic select_target(input logic [3:0] sel);	// la, up, as, is
		@(negedge axi_clk);
		{la_enable, up_enable, as_enable, is_enable} = sel;
	endtask

	function automatic data_t apply_strobes(input data_t old, input data_t word, input strb_t strb);
		data_t merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) merged[b*8 +: 8] = word[b*8 +: 8];
		end
		return merged;
	endfunction

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_after_reset();
		compare_bit("awready", awready, 1'b0);
		compare_bit("wready", wready, 1'b0);
		compare_bit("arready", arready, 1'b0);
		compare_bit("rvalid", rvalid, 1'b0);
		compare_data("switch_cfg", switch_cfg, '0);
		compare_bit("rx_enable", rx_enable, 1'b0);
		compare_bit("tx_enable", tx_enable, 1'b0);
		@(negedge axi_clk);
		awvalid = 1'b1;
		wvalid = 1'b1;
		repeat (10) begin
			@(negedge axi_clk);
			if (awready || wready) begin
				protocol_errors++;
				$display("a target answered a write while every enable was low");
			end
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic read_all(input logic from_up);
		data_t expected;
		for (int i = 0; i < num_words; i++) begin
			expected = from_up ? up_model[addr_list[i][mem_bits-1:0]]
				: la_model[addr_list[i][mem_bits-1:0]];
			read_word(addr_list[i], 0, got);
			compare_data("rdata", got, expected);
		end
	endtask

	task automatic test_memory();
		data_t word;
		select_target(4'b1000);
		for (int i = 0; i < num_words; i++) begin
			addr_list[i] = addr_t'($urandom());
			word = $urandom();
			la_model[addr_list[i][mem_bits-1:0]] = word;
			write_both(addr_list[i], word, '1);
		end
		read_all(1'b0);
		select_target(4'b0100);
		for (int i = 0; i < num_words; i++) begin
			word = ~la_model[addr_list[i][mem_bits-1:0]];
			up_model[addr_list[i][mem_bits-1:0]] = word;
			write_both(addr_list[i], word, '1);
		end
		read_all(1'b1);
		select_target(4'b1000);
		read_all(1'b0);	// la words survive the up writes
	endtask

	task automatic test_split();
		for (int i = 0; i < 4; i++) begin
			la_model[addr_list[i][mem_bits-1:0]] = $urandom();
			write_split(addr_list[i], la_model[addr_list[i][mem_bits-1:0]], 2 + i);
			read_word(addr_list[i], 0, got);
			compare_data("rdata", got, la_model[addr_list[i][mem_bits-1:0]]);
		end
	endtask

	task automatic test_backpressure();
		for (int i = 0; i < 4; i++) begin
			read_word(addr_list[i], 1 + int'($urandom() % 8), got);
			compare_data("rdata", got, la_model[addr_list[i][mem_bits-1:0]]);
			compare_bit("rvalid", rvalid, 1'b0);
			compare_data("rdata", rdata, '0);
		end
	endtask

	task automatic test_switch();
		data_t expected;
		data_t word;
		strb_t strb;
		select_target(4'b0010);
		expected = $urandom();
		write_both('0, expected, '1);
		compare_data("switch_cfg", switch_cfg, expected);
		repeat (3) begin
			word = $urandom();
			strb = strb_t'(1 + $urandom() % 14);	// never all or none
			expected = apply_strobes(expected, word, strb);
			write_both('0, word, strb);
			compare_data("switch_cfg", switch_cfg, expected);
		end
		write_both(15'h0004, ~expected, '1);
		compare_data("switch_cfg", switch_cfg, expected);
		read_word('0, 0, got);
		compare_data("rdata", got, expected);
	endtask

	task automatic serdes_write(input addr_t addr, input data_t word, input strb_t strb);
		if (addr[OFFSET_WIDTH-1:0] == '0 && strb[0]) serdes_expected = word[1:0];
		write_both(addr, word, strb);
		compare_bit("rx_enable", rx_enable, serdes_expected[0]);
		compare_bit("tx_enable", tx_enable, serdes_expected[1]);
	endtask

	task automatic test_serdes();
		select_target(4'b0001);
		serdes_expected = 2'b00;
		serdes_write('0, 32'h1, 4'h1);
		serdes_write('0, 32'h2, 4'hf);
		serdes_write('0, 32'h1, 4'he);	// lane 0 not strobed
		serdes_write(15'h0010, 32'h3, 4'hf);
		serdes_write('0, 32'h3, 4'h1);
		read_word('0, 0, got);
		compare_data("rdata", got, data_t'(serdes_expected));
	endtask

	initial begin
		void'($urandom(32'hff39_25bf));
		axi_reset_n = 1'b0;
		{awvalid, wvalid, arvalid, rready} = '0;
		{la_enable, up_enable, as_enable, is_enable} = '0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		repeat (2) @(negedge axi_clk);
		axi_reset_n = 1'b1;
		@(negedge axi_clk);
		test_after_reset();
		test_memory();
		test_split();
		test_backpressure();
		test_switch();
		test_serdes();
		@(negedge axi_clk);
		$display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- axil_target_cluster.f
+incdir+testbench
src/axil_target_pkg.sv
src/axil_mem_target.sv
src/axil_reg_target.sv
src/axil_target_cluster.sv
testbench/axil_target_cluster_assert.sv
testbench/axil_target_cluster_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module axil_target_cluster_tb \
	-f axil_target_cluster.f -o axil_target_cluster_sim \
	|| { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/axil_target_cluster_sim 2>&1)"
echo "$sim_out"
grep -qxF '*** PASSED ***' <<< "$sim_out" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
